// ==== verilog/nes_loader_pkg.sv ====
// Shared widths, address map and iNES header constants for the cartridge loader
// Every loader module refers to these by scoped name

package nes_loader_pkg;

	localparam int MEM_ADDR_W = 22;

	typedef logic [MEM_ADDR_W-1:0] mem_addr_t;
	typedef logic [7:0] byte_t;

	localparam int HEADER_BYTES = 16;
	localparam byte_t NES_MAGIC0 = 8'h4E; // 'N'
	localparam byte_t NES_MAGIC1 = 8'h45; // 'E'
	localparam byte_t NES_MAGIC2 = 8'h53; // 'S'
	localparam byte_t NES_MAGIC3 = 8'h1A;

	localparam int PRG_PAGE_SHIFT = 14; // 16 KB pages
	localparam int CHR_PAGE_SHIFT = 13; // 8 KB pages

	localparam mem_addr_t PRG_BASE = 22'h00_0000;
	localparam mem_addr_t CHR_BASE = 22'h20_0000;

	localparam int DL_RESET_CYCLES = 255;
	localparam int CE_DIVIDE = 4;

	// Mapper flag word handed to the console, low field last
	typedef struct packed {
		logic [6:0] spare;
		byte_t      nes2_ext;
		logic       four_screen;
		logic       chr_ram;
		logic       mirroring;
		logic [2:0] chr_size;
		logic [2:0] prg_size;
		byte_t      mapper;
	} mapper_flags_t;

	// Host order from bit 0: right, left, down, up, A, B, select, start
	typedef logic [7:0] joy_buttons_t;

endpackage

// ==== verilog/ines_header.sv ====
// Captures the 16-byte iNES header at the start of a download,
// validates it and decodes the mapper flag word

`timescale 1ns/10ps

module ines_header (
	input  logic                          clk,
	input  logic                          reset,
	input  logic                          loader_active,
	input  nes_loader_pkg::byte_t         dl_data,
	input  logic                          dl_wr,
	input  logic                          invert_mirroring,
	output logic                          header_ok,
	output logic                          header_bad,
	output nes_loader_pkg::byte_t         prg_pages,
	output nes_loader_pkg::byte_t         chr_pages,
	output nes_loader_pkg::mapper_flags_t mapper_flags
);

	nes_loader_pkg::byte_t hdr [nes_loader_pkg::HEADER_BYTES];
	logic [$clog2(nes_loader_pkg::HEADER_BYTES+1)-1:0] count;
	logic [$clog2(nes_loader_pkg::HEADER_BYTES+1)-1:0] idx;
	logic active_q;
	logic start;
	logic hdr_wr;
	logic magic_ok;
	logic accept;
	logic is_nes20;
	logic is_dirty;

	// Ceiling log2 of a page count, saturating at 7
	function automatic logic [2:0] size_class(input nes_loader_pkg::byte_t pages);
		logic [2:0] cls;
		int i;
		cls = 3'd0;
		for (i = 0; i < 7; i++) begin
			if (pages > (8'd1 << i))
				cls = 3'(i + 1);
		end
		return cls;
	endfunction

	assign start = loader_active & ~active_q; // New download begins
	assign idx = start ? '0 : count;
	assign hdr_wr = loader_active & dl_wr & (idx < nes_loader_pkg::HEADER_BYTES);

	assign magic_ok = (hdr[0] == nes_loader_pkg::NES_MAGIC0) &&
		(hdr[1] == nes_loader_pkg::NES_MAGIC1) &&
		(hdr[2] == nes_loader_pkg::NES_MAGIC2) &&
		(hdr[3] == nes_loader_pkg::NES_MAGIC3);
	assign accept = magic_ok & ~hdr[6][2]; // Trainers are not supported

	always_ff @(posedge clk) begin
		if (reset) begin
			active_q <= 1'b0;
			count <= '0;
			header_ok <= 1'b0;
			header_bad <= 1'b0;
		end else begin
			active_q <= loader_active;
			if (start) begin
				count <= '0;
				header_ok <= 1'b0;
				header_bad <= 1'b0;
			end
			if (hdr_wr) begin
				count <= idx + 1'b1;
				// Bytes 0 to 6 are already stored when the last one arrives
				if (idx == nes_loader_pkg::HEADER_BYTES - 1) begin
					header_ok <= accept;
					header_bad <= ~accept;
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (hdr_wr)
			hdr[idx[$clog2(nes_loader_pkg::HEADER_BYTES)-1:0]] <= dl_data;
	end

	assign prg_pages = hdr[4];
	assign chr_pages = hdr[5];
	assign is_nes20 = (hdr[7][3:2] == 2'b10);

	always_comb begin
		int n;
		is_dirty = 1'b0;
		for (n = 8; n < nes_loader_pkg::HEADER_BYTES; n++) begin
			if (hdr[n] != 8'h00)
				is_dirty = ~is_nes20; // Junk in the tail of an iNES 1.0 header
		end
	end

	always_comb begin
		mapper_flags.mapper = {is_dirty ? 4'h0 : hdr[7][7:4], hdr[6][7:4]};
		mapper_flags.prg_size = size_class(prg_pages);
		mapper_flags.chr_size = size_class(chr_pages);
		mapper_flags.mirroring = hdr[6][0] ^ invert_mirroring;
		mapper_flags.chr_ram = (chr_pages == 8'h00);
		mapper_flags.four_screen = hdr[6][3];
		mapper_flags.nes2_ext = is_nes20 ? hdr[8] : 8'h00;
		mapper_flags.spare = '0;
	end

endmodule

// ==== verilog/rom_placer.sv ====
// Places the PRG and CHR bytes that follow the header into cartridge memory
// and flags completion once the last write has had time to drain

`timescale 1ns/10ps

module rom_placer (
	input  logic                      clk,
	input  logic                      reset,
	input  logic                      loader_active,
	input  nes_loader_pkg::byte_t     dl_data,
	input  logic                      dl_wr,
	input  logic                      header_ok,
	input  nes_loader_pkg::byte_t     prg_pages,
	input  nes_loader_pkg::byte_t     chr_pages,
	output nes_loader_pkg::mem_addr_t wr_addr,
	output nes_loader_pkg::byte_t     wr_data,
	output logic                      wr_strobe,
	output logic                      done
);

	typedef enum logic [2:0] {PL_IDLE, PL_PRG, PL_CHR, PL_DRAIN, PL_DONE} place_state_t;

	place_state_t state;
	nes_loader_pkg::mem_addr_t addr_cnt;
	nes_loader_pkg::mem_addr_t bytes_left;
	nes_loader_pkg::mem_addr_t prg_bytes;
	nes_loader_pkg::mem_addr_t chr_bytes;
	logic [$clog2(nes_loader_pkg::CE_DIVIDE+1)-1:0] drain_cnt;
	logic active_q;
	logic start;
	logic data_wr;

	assign start = loader_active & ~active_q;
	assign data_wr = loader_active & dl_wr;
	assign prg_bytes = nes_loader_pkg::mem_addr_t'(prg_pages) << nes_loader_pkg::PRG_PAGE_SHIFT;
	assign chr_bytes = nes_loader_pkg::mem_addr_t'(chr_pages) << nes_loader_pkg::CHR_PAGE_SHIFT;

	always_ff @(posedge clk) begin
		if (reset)
			active_q <= 1'b0;
		else
			active_q <= loader_active;
	end

	always_ff @(posedge clk) begin
		if (reset || start) begin
			state <= PL_IDLE;
			wr_strobe <= 1'b0;
			done <= 1'b0;
			drain_cnt <= '0;
		end else begin
			wr_strobe <= 1'b0;
			case (state)
				PL_IDLE: if (header_ok) begin
					state <= PL_PRG;
					addr_cnt <= nes_loader_pkg::PRG_BASE;
					bytes_left <= prg_bytes;
				end
				PL_PRG, PL_CHR: begin
					if (bytes_left == '0) begin
						if (state == PL_PRG) begin
							state <= PL_CHR;
							addr_cnt <= nes_loader_pkg::CHR_BASE;
							bytes_left <= chr_bytes;
						end else begin
							state <= PL_DRAIN;
							drain_cnt <= ($bits(drain_cnt))'(nes_loader_pkg::CE_DIVIDE);
						end
					end else if (data_wr) begin
						wr_addr <= addr_cnt;
						wr_data <= dl_data;
						wr_strobe <= 1'b1;
						addr_cnt <= addr_cnt + 1'b1;
						bytes_left <= bytes_left - 1'b1;
					end
				end
				// Wait out one console slot so the final write reaches memory
				PL_DRAIN: begin
					if (drain_cnt == '0) begin
						done <= 1'b1;
						state <= PL_DONE;
					end else begin
						drain_cnt <= drain_cnt - 1'b1;
					end
				end
				PL_DONE: state <= PL_DONE; // Trailing bytes are dropped
				default: state <= PL_IDLE;
			endcase
		end
	end

endmodule

// ==== verilog/console_reset.sv ====
// Console clock enable and reset sequencing around ROM downloads
// Holds the console in reset from power-up until a download has finished its tail

`timescale 1ns/10ps

module console_reset (
	input  logic clk,
	input  logic reset,
	input  logic downloading,
	input  logic load_error,
	output logic nes_reset,
	output logic cpu_ce,
	output logic loader_active
);

	logic [$clog2(nes_loader_pkg::CE_DIVIDE)-1:0] ce_cnt;
	logic [$clog2(nes_loader_pkg::DL_RESET_CYCLES+1)-1:0] tail_cnt;
	logic hold;
	logic tail_busy;

	assign cpu_ce = (ce_cnt == nes_loader_pkg::CE_DIVIDE - 1); // One slot in four
	assign tail_busy = (tail_cnt != '0);
	assign loader_active = downloading | tail_busy;

	always_ff @(posedge clk) begin
		if (reset) begin
			ce_cnt <= '0;
			tail_cnt <= '0;
			hold <= 1'b1;
			nes_reset <= 1'b1;
		end else begin
			ce_cnt <= cpu_ce ? '0 : ce_cnt + 1'b1;

			// Tail restarts for as long as the host is still sending
			if (downloading)
				tail_cnt <= ($bits(tail_cnt))'(nes_loader_pkg::DL_RESET_CYCLES);
			else if (tail_busy)
				tail_cnt <= tail_cnt - 1'b1;

			if (downloading)
				hold <= 1'b0; // Power-up hold ends with the first download

			nes_reset <= hold | downloading | tail_busy | load_error;
		end
	end

endmodule

// ==== verilog/mem_write_stage.sv ====
// Holds one loader write and hands it to memory in the console enable slot
// The host spacing rule keeps at most one write pending

`timescale 1ns/10ps

module mem_write_stage (
	input  logic                      clk,
	input  logic                      reset,
	input  nes_loader_pkg::mem_addr_t wr_addr,
	input  nes_loader_pkg::byte_t     wr_data,
	input  logic                      wr_strobe,
	input  logic                      cpu_ce,
	output nes_loader_pkg::mem_addr_t mem_addr,
	output nes_loader_pkg::byte_t     mem_data,
	output logic                      mem_write
);

	logic pending;

	assign mem_write = pending & cpu_ce; // Pulse lands in the memory slot

	always_ff @(posedge clk) begin
		if (reset) begin
			pending <= 1'b0;
		end else begin
			if (mem_write)
				pending <= 1'b0;
			if (wr_strobe)
				pending <= 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (wr_strobe) begin
			mem_addr <= wr_addr;
			mem_data <= wr_data;
		end
	end

endmodule

// ==== verilog/joypad_ports.sv ====
// Two NES controller ports as serial shift registers
// Loaded on strobe, shifted on each falling edge of the port clock

`timescale 1ns/10ps

module joypad_ports (
	input  logic                         clk,
	input  logic                         nes_reset,
	input  nes_loader_pkg::joy_buttons_t joy_a,
	input  nes_loader_pkg::joy_buttons_t joy_b,
	input  logic                         joy_swap,
	input  logic                         joypad_strobe,
	input  logic [1:0]                   joypad_clock,
	output logic [1:0]                   joy_data
);

	nes_loader_pkg::byte_t port_bits [2];
	nes_loader_pkg::byte_t src [2];
	logic [1:0] clock_q;

	// NES order from bit 0: A, B, select, start, up, down, left, right
	function automatic nes_loader_pkg::byte_t to_nes_order(input nes_loader_pkg::joy_buttons_t h);
		return {h[0], h[1], h[2], h[3], h[7], h[6], h[5], h[4]};
	endfunction

	assign src[0] = joy_swap ? to_nes_order(joy_b) : to_nes_order(joy_a);
	assign src[1] = joy_swap ? to_nes_order(joy_a) : to_nes_order(joy_b);

	always_ff @(posedge clk) begin
		int n;
		if (nes_reset) begin
			port_bits[0] <= '0;
			port_bits[1] <= '0;
			clock_q <= '0;
		end else begin
			clock_q <= joypad_clock;
			for (n = 0; n < 2; n++) begin
				if (joypad_strobe)
					port_bits[n] <= src[n];
				else if (clock_q[n] & ~joypad_clock[n])
					port_bits[n] <= {1'b0, port_bits[n][7:1]}; // Zeros after the eighth read
			end
		end
	end

	assign joy_data = {port_bits[1][0], port_bits[0][0]};

endmodule

// ==== verilog/nes_loader_top.sv ====
// Cartridge loading path of the NES core with the controller ports beside it
// The host streams an iNES file byte by byte while downloading is high

`timescale 1ns/10ps

module nes_loader_top (
	input  logic                          clk,
	input  logic                          reset,
	input  logic                          downloading,
	input  nes_loader_pkg::byte_t         dl_data,
	input  logic                          dl_wr,
	input  logic                          invert_mirroring,
	input  nes_loader_pkg::joy_buttons_t  joy_a,
	input  nes_loader_pkg::joy_buttons_t  joy_b,
	input  logic                          joy_swap,
	input  logic                          joypad_strobe,
	input  logic [1:0]                    joypad_clock,
	output nes_loader_pkg::mem_addr_t     mem_addr,
	output nes_loader_pkg::byte_t         mem_data,
	output logic                          mem_write,
	output nes_loader_pkg::mapper_flags_t mapper_flags,
	output logic                          load_done,
	output logic                          load_error,
	output logic                          nes_reset,
	output logic                          cpu_ce,
	output logic [1:0]                    joy_data
);

	logic loader_active;
	logic header_ok;
	logic header_bad;
	nes_loader_pkg::byte_t prg_pages;
	nes_loader_pkg::byte_t chr_pages;
	nes_loader_pkg::mapper_flags_t header_flags;
	nes_loader_pkg::mem_addr_t wr_addr;
	nes_loader_pkg::byte_t wr_data;
	logic wr_strobe;
	logic place_done;

	assign load_error = header_bad;
	assign load_done = place_done | header_bad; // A rejected header ends the load at once

	always_ff @(posedge clk) begin
		if (reset)
			mapper_flags <= '0;
		else if (load_done)
			mapper_flags <= header_flags;
	end

	console_reset console_reset_i (.clk, .reset, .downloading, .load_error,
		.nes_reset, .cpu_ce, .loader_active);

	ines_header ines_header_i (.clk, .reset, .loader_active, .dl_data, .dl_wr,
		.invert_mirroring, .header_ok, .header_bad, .prg_pages, .chr_pages,
		.mapper_flags(header_flags));

	rom_placer rom_placer_i (.clk, .reset, .loader_active, .dl_data, .dl_wr, .header_ok,
		.prg_pages, .chr_pages, .wr_addr, .wr_data, .wr_strobe, .done(place_done));

	mem_write_stage mem_write_stage_i (.clk, .reset, .wr_addr, .wr_data, .wr_strobe,
		.cpu_ce, .mem_addr, .mem_data, .mem_write);

	joypad_ports joypad_ports_i (.clk, .nes_reset, .joy_a, .joy_b, .joy_swap,
		.joypad_strobe, .joypad_clock, .joy_data);

endmodule

// ==== bench/tb_nes_loader.sv ====
// Testbench for the cartridge loader: streams random iNES images into the DUT,
// checks each memory write, the latched flag word, reset timing and the joypads

`timescale 1ns/10ps

module tb_nes_loader;

	localparam int PRG_BYTES = 1 << nes_loader_pkg::PRG_PAGE_SHIFT;
	localparam int CHR_BYTES = 1 << nes_loader_pkg::CHR_PAGE_SHIFT;
	localparam int BAD_DATA_BYTES = 64; // Sent after a rejected header

	logic clk;
	logic reset;
	logic downloading;
	nes_loader_pkg::byte_t dl_data;
	logic dl_wr;
	logic invert_mirroring;
	nes_loader_pkg::joy_buttons_t joy_a;
	nes_loader_pkg::joy_buttons_t joy_b;
	logic joy_swap;
	logic joypad_strobe;
	logic [1:0] joypad_clock;
	nes_loader_pkg::mem_addr_t mem_addr;
	nes_loader_pkg::byte_t mem_data;
	logic mem_write;
	nes_loader_pkg::mapper_flags_t mapper_flags;
	logic load_done;
	logic load_error;
	logic nes_reset;
	logic cpu_ce;
	logic [1:0] joy_data;

	nes_loader_pkg::byte_t image [$]; // Whole iNES file, header first
	nes_loader_pkg::mem_addr_t exp_addr [$];
	nes_loader_pkg::byte_t exp_data [$];
	string test_name;
	int write_count;
	int budget_cycles = 0;
	int prg_sel [4];
	int chr_sel [4];

	nes_loader_top nes_loader_top_i (.*);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	task automatic stop_failed(input string msg);
		$display("%s", msg);
		$display("Simulation failed");
		$fatal(1, "stopped at the first error");
	endtask

	task automatic check_write(input string name, input nes_loader_pkg::mem_addr_t exp_a,
		input nes_loader_pkg::byte_t exp_d, input nes_loader_pkg::mem_addr_t act_a,
		input nes_loader_pkg::byte_t act_d);
		if (exp_a !== act_a || exp_d !== act_d)
			stop_failed($sformatf("Fail %s: expected %h/%h, actual %h/%h",
				name, exp_a, exp_d, act_a, act_d));
	endtask

	task automatic check_flags(input string name, input nes_loader_pkg::mapper_flags_t exp,
		input nes_loader_pkg::mapper_flags_t act);
		if (exp !== act)
			stop_failed($sformatf("Fail %s: expected %h, actual %h", name, exp, act));
	endtask

	task automatic check_bit(input string name, input logic exp, input logic act);
		if (exp !== act)
			stop_failed($sformatf("Fail %s: expected %b, actual %b", name, exp, act));
	endtask

	task automatic check_count(input string name, input int exp, input int act);
		if (exp != act)
			stop_failed($sformatf("Fail %s: expected %0d, actual %0d", name, exp, act));
	endtask

	task automatic step();
		@(posedge clk);
		#10;
	endtask

	// Page count to size class, smallest c with 2**c >= pages, capped at 7
	function automatic logic [2:0] page_class(input int pages);
		int c = 0;
		while (c < 7 && (1 << c) < pages)
			c++;
		return 3'(c);
	endfunction

	function automatic nes_loader_pkg::mapper_flags_t model_flags(input logic inv);
		nes_loader_pkg::mapper_flags_t f;
		logic nes20;
		logic dirty;
		int n;
		nes20 = (image[7][3:2] == 2'b10);
		dirty = 1'b0;
		for (n = 8; n < 16; n++) begin
			if (!nes20 && image[n] != 8'h00)
				dirty = 1'b1;
		end
		f = '0;
		f.mapper = {dirty ? 4'h0 : image[7][7:4], image[6][7:4]};
		f.prg_size = page_class(int'(image[4]));
		f.chr_size = page_class(int'(image[5]));
		f.mirroring = image[6][0] ^ inv;
		f.chr_ram = (image[5] == 8'h00);
		f.four_screen = image[6][3];
		f.nes2_ext = nes20 ? image[8] : 8'h00;
		return f;
	endfunction

	// Host order to console order: A, B, select, start, then up, down, left, right
	function automatic nes_loader_pkg::byte_t nes_order(input nes_loader_pkg::joy_buttons_t h);
		nes_loader_pkg::byte_t r;
		int i;
		for (i = 0; i < 4; i++)
			r[i] = h[i + 4];
		for (i = 4; i < 8; i++)
			r[i] = h[7 - i];
		return r;
	endfunction

	// Serial bit of a port after a number of shifts, zeros after the eighth
	function automatic logic serial_bit(input nes_loader_pkg::byte_t v, input int shifts);
		return (shifts < 8) ? v[shifts] : 1'b0;
	endfunction

	// Kinds: 0 clean, 1 dirty, 2 NES 2.0, 3 bad magic, 4 trainer
	task automatic make_header(input int kind, input int prg, input int chr);
		nes_loader_pkg::byte_t h [16];
		int n;
		h[0] = nes_loader_pkg::NES_MAGIC0;
		h[1] = nes_loader_pkg::NES_MAGIC1;
		h[2] = nes_loader_pkg::NES_MAGIC2;
		h[3] = nes_loader_pkg::NES_MAGIC3;
		h[4] = nes_loader_pkg::byte_t'(prg);
		h[5] = nes_loader_pkg::byte_t'(chr);
		h[6] = nes_loader_pkg::byte_t'($urandom) & 8'hFB; // No trainer
		h[7] = nes_loader_pkg::byte_t'($urandom) & 8'hF3;
		for (n = 8; n < 16; n++)
			h[n] = 8'h00;
		case (kind)
			1: begin
				h[7][4] = 1'b1; // Upper mapper nibble that a dirty header loses
				h[8 + $urandom % 8] = nes_loader_pkg::byte_t'($urandom % 255 + 1);
			end
			2: begin
				h[7][3:2] = 2'b10;
				h[7][4] = 1'b1;
				for (n = 8; n < 16; n++)
					h[n] = nes_loader_pkg::byte_t'($urandom);
				h[8][0] = 1'b1; // Extension byte never zero
			end
			3: h[$urandom % 4] = 8'h00;
			4: h[6][2] = 1'b1;
			default: ;
		endcase
		image.delete();
		for (n = 0; n < 16; n++)
			image.push_back(h[n]);
	endtask

	task automatic add_data(input int count);
		int i;
		for (i = 0; i < count; i++)
			image.push_back(nes_loader_pkg::byte_t'($urandom));
	endtask

	// One strobe per console slot, then wait for the load to end
	task automatic send_image();
		int i;
		write_count = 0;
		downloading = 1'b1;
		step();
		step();
		for (i = 0; i < image.size(); i++) begin
			dl_data = image[i];
			dl_wr = 1'b1;
			step();
			dl_wr = 1'b0;
			repeat (nes_loader_pkg::CE_DIVIDE - 1) step();
		end
		@(negedge clk);
		while (!load_done)
			@(negedge clk);
		@(posedge clk); // Flag word is latched one clock after load_done
		@(negedge clk);
	endtask

	task automatic run_good(input string name, input int kind, input int prg, input int chr);
		int cycles;
		int i;
		step();
		test_name = name;
		invert_mirroring = 1'($urandom);
		make_header(kind, prg, chr);
		add_data(prg * PRG_BYTES + chr * CHR_BYTES);
		for (i = 0; i < prg * PRG_BYTES; i++) begin
			exp_addr.push_back(nes_loader_pkg::PRG_BASE + nes_loader_pkg::mem_addr_t'(i));
			exp_data.push_back(image[16 + i]);
		end
		for (i = 0; i < chr * CHR_BYTES; i++) begin
			exp_addr.push_back(nes_loader_pkg::CHR_BASE + nes_loader_pkg::mem_addr_t'(i));
			exp_data.push_back(image[16 + prg * PRG_BYTES + i]);
		end
		send_image();
		if (exp_addr.size() != 0)
			stop_failed($sformatf("%s: %0d writes never reached memory", name, exp_addr.size()));
		check_bit({name, " load_error"}, 1'b0, load_error);
		check_flags({name, " mapper_flags"}, model_flags(invert_mirroring), mapper_flags);
		step();
		downloading = 1'b0;
		cycles = 0;
		@(negedge clk);
		while (nes_reset) begin
			cycles++;
			@(negedge clk);
		end
		check_count({name, " reset tail"}, nes_loader_pkg::DL_RESET_CYCLES + 1, cycles);
	endtask

	task automatic run_bad(input string name, input int kind);
		step();
		test_name = name;
		make_header(kind, 1, 1);
		add_data(BAD_DATA_BYTES);
		send_image();
		check_bit({name, " load_error"}, 1'b1, load_error);
		step();
		downloading = 1'b0;
		repeat (nes_loader_pkg::DL_RESET_CYCLES + 20) begin // Past the end of the tail
			@(negedge clk);
			check_bit({name, " nes_reset held"}, 1'b1, nes_reset);
		end
	endtask

	task automatic run_joypad(input int round);
		nes_loader_pkg::byte_t exp0;
		nes_loader_pkg::byte_t exp1;
		int i;
		step();
		test_name = $sformatf("joypad %0d", round);
		joy_a = nes_loader_pkg::joy_buttons_t'($urandom);
		joy_b = nes_loader_pkg::joy_buttons_t'($urandom);
		joy_swap = round[0];
		exp0 = nes_order(joy_swap ? joy_b : joy_a);
		exp1 = nes_order(joy_swap ? joy_a : joy_b);
		joypad_strobe = 1'b1;
		step();
		joypad_strobe = 1'b0;
		// Clock bits take turns, so port 0 runs one shift ahead of port 1
		for (i = 0; i < 20; i++) begin
			@(negedge clk);
			check_bit($sformatf("%s port 0 read %0d", test_name, (i + 1) / 2),
				serial_bit(exp0, (i + 1) / 2), joy_data[0]);
			check_bit($sformatf("%s port 1 read %0d", test_name, i / 2),
				serial_bit(exp1, i / 2), joy_data[1]);
			step();
			joypad_clock = i[0] ? 2'b10 : 2'b01;
			step();
			joypad_clock = 2'b00; // Falling edge shifts one port only
			step();
		end
	endtask

	// Every memory write is checked against the model queue as it happens,
	// and cpu_ce against its one-in-four slot
	initial begin
		int ce_clocks;
		ce_clocks = 0;
		forever begin
			@(negedge clk);
			if (reset) begin
				ce_clocks = 0;
			end else begin
				ce_clocks++;
				check_bit("cpu_ce slot", (ce_clocks % nes_loader_pkg::CE_DIVIDE) == 0, cpu_ce);
			end
			if (!reset && mem_write) begin
				check_bit("mem_write in a cpu_ce slot", 1'b1, cpu_ce);
				if (exp_addr.size() == 0)
					stop_failed($sformatf("%s: mem_write with no write expected", test_name));
				check_write($sformatf("%s write %0d", test_name, write_count),
					exp_addr.pop_front(), exp_data.pop_front(), mem_addr, mem_data);
				write_count++;
			end
		end
	end

	initial begin
		wait (budget_cycles > 0);
		repeat (budget_cycles) @(posedge clk);
		stop_failed("Watchdog expired before the tests finished");
	end

	initial begin
		int total_bytes;
		int k;
		void'($urandom(47));
		reset = 1'b1;
		downloading = 1'b0;
		dl_data = 8'h00;
		dl_wr = 1'b0;
		invert_mirroring = 1'b0;
		joy_a = 8'h00;
		joy_b = 8'h00;
		joy_swap = 1'b0;
		joypad_strobe = 1'b0;
		joypad_clock = 2'b00;
		test_name = "reset";
		write_count = 0;
		total_bytes = 2 * (16 + BAD_DATA_BYTES);
		for (k = 0; k < 4; k++) begin
			prg_sel[k] = 1 + $urandom % 2;
			chr_sel[k] = $urandom % 2;
			total_bytes += 16 + prg_sel[k] * PRG_BYTES + chr_sel[k] * CHR_BYTES;
		end
		// Strobe spacing per byte, plus the reset tail of each of the six downloads
		budget_cycles = total_bytes * nes_loader_pkg::CE_DIVIDE
			+ 6 * (nes_loader_pkg::DL_RESET_CYCLES + 40) + 2000;
		repeat (4) @(posedge clk);
		#10;
		reset = 1'b0;
		repeat (8) begin
			@(negedge clk);
			check_bit("nes_reset before first download", 1'b1, nes_reset);
			check_bit("load_done after reset", 1'b0, load_done);
			check_bit("load_error after reset", 1'b0, load_error);
			check_bit("mem_write after reset", 1'b0, mem_write);
		end
		run_good("clean header", 0, prg_sel[0], chr_sel[0]);
		run_bad("bad magic", 3);
		run_good("dirty header", 1, prg_sel[1], chr_sel[1]);
		run_bad("trainer set", 4);
		run_good("nes 2.0 header", 2, prg_sel[2], chr_sel[2]);
		run_good("random header", int'($urandom % 3), prg_sel[3], chr_sel[3]);
		run_joypad(0);
		run_joypad(1);
		$display("Simulation passed");
		$finish;
	end

endmodule

// ==== build.f ====
verilog/nes_loader_pkg.sv
verilog/ines_header.sv
verilog/rom_placer.sv
verilog/console_reset.sv
verilog/mem_write_stage.sv
verilog/joypad_ports.sv
verilog/nes_loader_top.sv
bench/tb_nes_loader.sv

// ==== run.sh ====
#!/bin/sh
# Compile the loader testbench with Verilator, run it and check the log

cd "$(dirname "$0")" \
	&& rm -rf obj_dir sim.log \
	&& verilator --binary --timing -Wno-fatal --top-module tb_nes_loader -f build.f \
	&& ./obj_dir/Vtb_nes_loader > sim.log 2>&1 \
	&& grep -q "^Simulation passed$" sim.log \
	&& echo "Run passed" \
	|| { echo "Run failed, see sim.log"; exit 1; }
